// File: include/spif_params.svh
/* widths, memory sizes and boot constants for the flash companion block.
   included by every design file that sizes a port or a register */
`ifndef SPIF_PARAMS_SVH
`define SPIF_PARAMS_SVH

// ============================================================
// word and memory sizes
// ============================================================
`define SPIF_WIDTH      18          // data word width
`define SPIF_CODE_SIZE  10          // log2 of code words
`define SPIF_DATA_SIZE  10          // log2 of data cells
`define SPIF_ADDR_W     15          // processor address width
`define SPIF_INSN_W     16          // code word width

// ============================================================
// flash and uart constants
// ============================================================
`define SPIF_FAST_READ  8'h0B       // spi fast read opcode
`define SPIF_BASEBLOCK  8'h00       // first 64k flash block of the script
`define SPIF_ESC_BYTE   8'h10       // uart escape prefix
`define SPIF_RATE_RESET 4'd7        // sclk divisor out of reset

`endif

// File: design/spif_pkg.sv
/* state, mode and register index types shared by the design and testbench */
package spif_pkg;

  // flash transfer sequence
  typedef enum logic [2:0] {
    idle,                           // clear running or boot finished
    cmd,                            // send fast read opcode
    addr_hi,                        // send block number
    addr_mid,
    addr_lo,
    dummy,                          // fast read dummy byte
    interp                          // script bytes
  } boot_state_e;

  // what the next script byte means
  typedef enum logic [3:0] {
    command,
    set_addr_hi,
    set_addr_lo,
    set_len_hi,
    set_len_lo,
    write_code,
    write_data,
    write_none                      // run with no sink, bytes skipped
  } boot_mode_e;

  typedef enum logic [0:0] {
    rx_idle,
    rx_esc                          // 10h seen, next byte is escaped
  } rx_state_e;

  // processor i/o register index
  typedef enum logic [2:0] {
    io_uart      = 3'd0,
    io_rxfull    = 3'd1,
    io_txbusy    = 3'd2,
    io_flash     = 3'd3,
    io_code_addr = 3'd4,
    io_code_data = 3'd5,
    io_booting   = 3'd6
  } io_reg_e;

endpackage

// File: design/spif_if.sv
/* internal links of the block. boot_wr_if carries boot dma writes and status,
   uart_io_if joins the i/o decode to the uart registers */
`include "spif_params.svh"

interface boot_wr_if;
  logic                   code_we;      // code ram write strobe
  logic                   data_we;      // data ram write strobe
  logic [15:0]            addr;         // boot write address
  logic [`SPIF_WIDTH-1:0] wdata;        // held while a strobe is high
  logic                   booting;      // clear or script still running
  logic [7:0]             flash_byte;   // last plain byte from flash

  modport master (
    output code_we, data_we, addr, wdata, booting, flash_byte
  );

  modport slave (
    input  code_we, data_we, addr, wdata, booting, flash_byte
  );
endinterface

interface uart_io_if;
  logic       tx_write;                 // load transmit register
  logic       rx_clear;                 // receive byte taken
  logic [7:0] wdata;                    // byte to send
  logic [7:0] rx_byte;                  // receive holding register
  logic       rx_full;
  logic       tx_busy;                  // uart cannot take a byte

  modport cpu (
    output tx_write, rx_clear, wdata,
    input  rx_byte, rx_full, tx_busy
  );

  modport uart (
    input  tx_write, rx_clear, wdata,
    output rx_byte, rx_full, tx_busy
  );
endinterface

// File: design/spram.sv
/* single-port ram with a registered read, data one cycle after i_re */
module spram #(
  parameter int addr_width = 10,
  parameter int data_width = 18
) (
  input  logic                  clk,
  input  logic [addr_width-1:0] i_addr,
  input  logic [data_width-1:0] i_din,
  input  logic                  i_we,
  input  logic                  i_re,     // load o_dout
  output logic [data_width-1:0] o_dout
);

  logic [data_width-1:0] mem [0:(1 << addr_width) - 1];

  always_ff @(posedge clk) begin
    if (i_we) mem[i_addr] <= i_din;
    if (i_re) o_dout <= mem[i_addr];      // old data on a same-cycle write
  end

endmodule

// File: design/boot_interp.sv
/* flash boot sequencer. clears both rams after reset, sends the fast read
   header, then interprets script bytes into code and data ram writes */
`include "spif_params.svh"

module boot_interp (
  input  logic       clk,
  input  logic       arstn,
  input  logic       i_f_ready,     // flash can start a transfer
  input  logic [7:0] i_f_din,       // byte returned by the last transfer
  output logic       o_f_wr,        // transfer strobe
  output logic [7:0] o_f_dout,      // byte sent by the transfer
  output logic [3:0] o_f_rate,      // sclk divisor
  output logic       o_p_reset,
  boot_wr_if.master  bus
);
  import spif_pkg::*;

  boot_state_e                state;
  boot_mode_e                 mode;
  logic                       clearing;   // power-up ram clear
  logic [`SPIF_CODE_SIZE-1:0] clr_cnt;
  logic                       primed;     // dummy return consumed
  logic                       code_wr;
  logic                       data_wr;
  logic                       skip_wr;    // word of a sinkless run
  logic [15:0]                count;      // words left in run minus one
  logic [1:0]                 bytes;      // bytes per word minus one
  logic [1:0]                 byte_cnt;
  logic                       f_ok;
  logic                       bump;

  assign f_ok           = i_f_ready & ~o_f_wr & ~clearing & (state != idle);
  assign bus.code_we    = clearing | code_wr;
  assign bus.data_we    = clearing | data_wr;
  assign bus.booting    = clearing | (state != idle);
  assign bus.flash_byte = i_f_din;          // no cypher, flash bytes are plain
  assign bump           = bus.code_we | bus.data_we | skip_wr;

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      state     <= idle;
      mode      <= command;
      clearing  <= 1'b1;
      clr_cnt   <= '0;
      primed    <= 1'b0;
      code_wr   <= 1'b0;
      data_wr   <= 1'b0;
      skip_wr   <= 1'b0;
      count     <= '0;
      bytes     <= 2'd0;
      byte_cnt  <= 2'd0;
      o_f_wr    <= 1'b0;
      o_f_dout  <= 8'h00;
      o_f_rate  <= `SPIF_RATE_RESET;
      o_p_reset <= 1'b1;
      bus.addr  <= '0;
      bus.wdata <= '0;                      // clear writes zeros
    end else begin
      code_wr <= 1'b0;                      // strobes
      data_wr <= 1'b0;
      skip_wr <= 1'b0;
      o_f_wr  <= 1'b0;
      if (clearing) begin
        clr_cnt <= clr_cnt + 1'b1;
        if (&clr_cnt) begin                 // last address written
          clearing <= 1'b0;
          state    <= cmd;
        end
      end else if (f_ok) begin
        o_f_wr   <= 1'b1;
        o_f_dout <= 8'h00;
        case (state)
          cmd: begin
            o_f_dout <= `SPIF_FAST_READ;
            state    <= addr_hi;
          end
          addr_hi: begin
            o_f_dout <= `SPIF_BASEBLOCK;
            state    <= addr_mid;
          end
          addr_mid: state <= addr_lo;
          addr_lo:  state <= dummy;
          dummy:    state <= interp;
          default: begin
            // ============================================================
            // script interpreter, byte from the previous transfer
            // ============================================================
            primed <= 1'b1;                 // first return is the dummy's
            if (primed) begin
              case (mode)
                command: begin
                  if (i_f_din[7:6] == 2'b11) begin
                    if (i_f_din[5]) begin   // end of script
                      o_f_wr    <= 1'b0;
                      state     <= idle;
                      o_p_reset <= i_f_din[4];
                    end else if (i_f_din[1:0] == 2'b00) begin
                      mode <= set_addr_hi;
                    end else if (i_f_din[1:0] == 2'b01) begin
                      mode <= set_len_hi;
                    end
                  end else if (i_f_din[7]) begin
                    o_f_rate <= i_f_din[3:0];
                  end else begin            // start a data run
                    bytes    <= i_f_din[1:0];
                    byte_cnt <= i_f_din[1:0];
                    case (i_f_din[4:3])
                      2'd0:    mode <= write_code;
                      2'd1:    mode <= write_data;
                      default: mode <= write_none;
                    endcase
                  end
                end
                set_addr_hi: begin
                  bus.addr[15:8] <= i_f_din;
                  mode           <= set_addr_lo;
                end
                set_addr_lo: begin
                  bus.addr[7:0] <= i_f_din;
                  mode          <= command;
                end
                set_len_hi: begin
                  count[15:8] <= i_f_din;
                  mode        <= set_len_lo;
                end
                set_len_lo: begin
                  count[7:0] <= i_f_din;
                  mode       <= command;
                end
                default: begin              // write modes, msb first
                  bus.wdata <= {bus.wdata[`SPIF_WIDTH-9:0], i_f_din};
                  if (byte_cnt != 2'd0) begin
                    byte_cnt <= byte_cnt - 2'd1;
                  end else begin
                    byte_cnt <= bytes;
                    code_wr  <= (mode == write_code);
                    data_wr  <= (mode == write_data);
                    skip_wr  <= (mode == write_none);
                    if (count != 16'd0) count <= count - 16'd1;
                    else mode <= command;
                  end
                end
              endcase
            end
          end
        endcase
      end
      if (bump) begin                       // next word
        bus.addr  <= bus.addr + 16'd1;
        bus.wdata <= '0;
      end
    end
  end

endmodule

// File: design/uart_port.sv
/* processor uart. decodes the 10h escape on receive into a holding register
   and loads the transmit register from i/o writes */
`include "spif_params.svh"

module uart_port (
  input  logic       clk,
  input  logic       arstn,
  input  logic       i_u_ready,     // tx can take a byte
  input  logic       i_u_full,      // rx byte waiting
  input  logic [7:0] i_u_din,
  output logic       o_u_rd,        // take rx byte
  output logic       o_u_wr,        // send tx byte
  output logic [7:0] o_u_dout,
  uart_io_if.uart    io
);
  import spif_pkg::*;

  localparam logic [7:0] esc = `SPIF_ESC_BYTE;

  rx_state_e rx_state;
  logic      rx_ok;                 // raw byte can be taken
  logic      esc_group;             // 10h to 13h

  assign rx_ok      = i_u_full & ~o_u_rd;
  assign esc_group  = (i_u_din[7:2] == esc[7:2]);
  assign io.tx_busy = ~i_u_ready;

  // ============================================================
  // receive decoder
  // ============================================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      rx_state   <= rx_idle;
      o_u_rd     <= 1'b0;
      io.rx_full <= 1'b0;
      io.rx_byte <= 8'h00;
    end else begin
      o_u_rd <= 1'b0;
      if (io.rx_clear) io.rx_full <= 1'b0;  // a new byte below wins
      if (rx_ok) begin
        case (rx_state)
          rx_idle: begin
            if (esc_group) begin
              o_u_rd <= 1'b1;               // 11h..13h just dropped
              if (i_u_din[1:0] == 2'b00) rx_state <= rx_esc;
            end else if (!io.rx_full) begin // back-pressure while full
              o_u_rd     <= 1'b1;
              io.rx_byte <= i_u_din;
              io.rx_full <= 1'b1;
            end
          end
          default: begin
            if (!io.rx_full) begin
              o_u_rd     <= 1'b1;
              io.rx_byte <= {esc[7:2], i_u_din[1:0]};
              io.rx_full <= 1'b1;
              rx_state   <= rx_idle;
            end
          end
        endcase
      end
    end
  end

  // transmit register
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) o_u_wr <= 1'b0;
    else        o_u_wr <= io.tx_write;
  end

  always_ff @(posedge clk) begin
    if (io.tx_write) o_u_dout <= io.wdata;
  end

endmodule

// File: design/mem_port.sv
/* access combiner. muxes boot and processor writes onto the two rams,
   decodes the i/o registers and stalls the processor */
`include "spif_params.svh"

module mem_port (
  input  logic                    clk,
  input  logic                    arstn,
  input  logic                    i_io_rd,
  input  logic                    i_io_wr,
  input  logic                    i_mem_rd,
  input  logic                    i_mem_wr,
  input  logic [`SPIF_ADDR_W-1:0] i_mem_addr,
  input  logic [`SPIF_WIDTH-1:0]  i_din,
  input  logic [`SPIF_ADDR_W-1:0] i_code_addr,
  output logic [`SPIF_WIDTH-1:0]  o_mem_dout,
  output logic [`SPIF_WIDTH-1:0]  o_io_dout,
  output logic [`SPIF_INSN_W-1:0] o_insn,
  output logic                    o_p_hold,
  boot_wr_if.slave                boot,
  uart_io_if.cpu                  uart
);
  import spif_pkg::*;

  io_reg_e                    io_sel;
  logic                       internal;       // address below 10h
  logic                       tx_req;         // cpu wants to send
  logic                       io_wr_ok;
  logic                       cpu_code_we;
  logic [15:0]                cpu_code_addr;  // cpu's own code write pointer
  logic [`SPIF_CODE_SIZE-1:0] code_ia;
  logic [`SPIF_INSN_W-1:0]    code_din;
  logic [`SPIF_DATA_SIZE-1:0] data_ia;
  logic [`SPIF_WIDTH-1:0]     data_din;
  logic [`SPIF_WIDTH-1:0]     io_rd_data;

  assign io_sel   = io_reg_e'(i_mem_addr[2:0]);
  assign internal = (i_mem_addr[`SPIF_ADDR_W-1:4] == '0);
  assign tx_req   = i_io_wr & internal & (io_sel == io_uart);
  assign o_p_hold = boot.code_we | boot.data_we | (tx_req & uart.tx_busy);
  assign io_wr_ok = i_io_wr & internal & ~o_p_hold;

  assign uart.tx_write = tx_req & ~o_p_hold;
  assign uart.wdata    = i_din[7:0];
  assign uart.rx_clear = i_io_rd & internal & ~o_p_hold & (io_sel == io_uart);
  assign cpu_code_we   = io_wr_ok & (io_sel == io_code_data);

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) cpu_code_addr <= '0;
    else if (io_wr_ok && io_sel == io_code_addr) cpu_code_addr <= i_din[15:0];
    else if (cpu_code_we) cpu_code_addr <= cpu_code_addr + 16'd1;
  end

  // ============================================================
  // ram ports, boot strobes win
  // ============================================================
  assign code_ia  = boot.code_we ? boot.addr[`SPIF_CODE_SIZE-1:0] :
                    cpu_code_we  ? cpu_code_addr[`SPIF_CODE_SIZE-1:0] :
                                   i_code_addr[`SPIF_CODE_SIZE-1:0];
  assign code_din = boot.code_we ? boot.wdata[`SPIF_INSN_W-1:0] : i_din[`SPIF_INSN_W-1:0];
  assign data_ia  = boot.data_we ? boot.addr[`SPIF_DATA_SIZE-1:0]
                                 : i_mem_addr[`SPIF_DATA_SIZE-1:0];
  assign data_din = boot.data_we ? boot.wdata : i_din;

  spram #(.addr_width(`SPIF_CODE_SIZE), .data_width(`SPIF_INSN_W)) code_ram (
    .clk    (clk),
    .i_addr (code_ia),
    .i_din  (code_din),
    .i_we   (boot.code_we | cpu_code_we),
    .i_re   (~o_p_hold & ~cpu_code_we),   // fetch keeps last word on cpu write
    .o_dout (o_insn)
  );

  spram #(.addr_width(`SPIF_DATA_SIZE), .data_width(`SPIF_WIDTH)) data_ram (
    .clk    (clk),
    .i_addr (data_ia),
    .i_din  (data_din),
    .i_we   (boot.data_we | (i_mem_wr & ~o_p_hold)),
    .i_re   (i_mem_rd & ~o_p_hold),
    .o_dout (o_mem_dout)
  );

  // i/o read mux, zero extended
  always_comb begin
    io_rd_data = '0;
    case (io_sel)
      io_uart:      io_rd_data[7:0]  = uart.rx_byte;
      io_rxfull:    io_rd_data[0]    = uart.rx_full;
      io_txbusy:    io_rd_data[0]    = uart.tx_busy;
      io_flash:     io_rd_data[7:0]  = boot.flash_byte;
      io_code_addr: io_rd_data[15:0] = cpu_code_addr;
      io_booting:   io_rd_data[0]    = boot.booting;
      default:      io_rd_data       = '0;  // code data is write only
    endcase
  end

  assign o_io_dout = internal ? io_rd_data : '0;

endmodule

// File: design/spif.sv
/* top level of the flash companion block. boots the processor from spi flash,
   then serves its uart, i/o registers and code and data rams */
`include "spif_params.svh"

module spif (
  input  logic                    clk,
  input  logic                    arstn,        // async reset, active low
  // ============================================================
  // processor
  // ============================================================
  input  logic                    i_io_rd,      // i/o read strobe
  input  logic                    i_io_wr,      // i/o write strobe
  input  logic                    i_mem_rd,     // data ram read enable
  input  logic                    i_mem_wr,     // data ram write enable
  input  logic [`SPIF_ADDR_W-1:0] i_mem_addr,   // data and i/o address
  input  logic [`SPIF_WIDTH-1:0]  i_din,        // data and i/o write data
  input  logic [`SPIF_ADDR_W-1:0] i_code_addr,  // fetch address
  output logic [`SPIF_WIDTH-1:0]  o_mem_dout,
  output logic [`SPIF_WIDTH-1:0]  o_io_dout,
  output logic [`SPIF_INSN_W-1:0] o_insn,
  output logic                    o_p_hold,     // stall the processor
  output logic                    o_p_reset,    // processor reset
  // ============================================================
  // uart
  // ============================================================
  input  logic                    i_u_ready,    // tx can take a byte
  output logic                    o_u_wr,
  output logic [7:0]              o_u_dout,
  input  logic                    i_u_full,     // rx byte waiting
  output logic                    o_u_rd,
  input  logic [7:0]              i_u_din,
  // ============================================================
  // spi flash byte port
  // ============================================================
  input  logic                    i_f_ready,
  output logic                    o_f_wr,
  output logic [7:0]              o_f_dout,
  output logic [3:0]              o_f_rate,     // sclk divisor
  input  logic [7:0]              i_f_din
);

  boot_wr_if boot_bus ();
  uart_io_if uart_bus ();

  boot_interp u_boot (
    .clk       (clk),
    .arstn     (arstn),
    .i_f_ready (i_f_ready),
    .i_f_din   (i_f_din),
    .o_f_wr    (o_f_wr),
    .o_f_dout  (o_f_dout),
    .o_f_rate  (o_f_rate),
    .o_p_reset (o_p_reset),
    .bus       (boot_bus)
  );

  uart_port u_uart (
    .clk       (clk),
    .arstn     (arstn),
    .i_u_ready (i_u_ready),
    .i_u_full  (i_u_full),
    .i_u_din   (i_u_din),
    .o_u_rd    (o_u_rd),
    .o_u_wr    (o_u_wr),
    .o_u_dout  (o_u_dout),
    .io        (uart_bus)
  );

  mem_port u_mem (
    .clk         (clk),
    .arstn       (arstn),
    .i_io_rd     (i_io_rd),
    .i_io_wr     (i_io_wr),
    .i_mem_rd    (i_mem_rd),
    .i_mem_wr    (i_mem_wr),
    .i_mem_addr  (i_mem_addr),
    .i_din       (i_din),
    .i_code_addr (i_code_addr),
    .o_mem_dout  (o_mem_dout),
    .o_io_dout   (o_io_dout),
    .o_insn      (o_insn),
    .o_p_hold    (o_p_hold),
    .boot        (boot_bus),
    .uart        (uart_bus)
  );

endmodule

// File: verification/spif_chk.sv
/* protocol assertions on the spif top level, attached by bind */
module spif_chk (
  input logic clk,
  input logic arstn,
  input logic o_u_wr,
  input logic i_u_ready,
  input logic o_f_wr,
  input logic o_u_rd,
  input logic o_p_hold
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [10:0] clr_cycles;              // cycles since reset release

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) clr_cycles <= '0;
    else if (clr_cycles != 11'd1100) clr_cycles <= clr_cycles + 11'd1;
  end

  // ============================================================
  // handshake rules
  // ============================================================
  a_u_wr_ready: assert property (@(posedge clk) disable iff (!arstn)
    $rose(o_u_wr) |-> $past(i_u_ready)) else $error("uart write while not ready");

  a_f_wr_pulse: assert property (@(posedge clk) disable iff (!arstn)
    o_f_wr |=> !o_f_wr) else $error("flash strobe longer than one cycle");

  a_u_rd_pulse: assert property (@(posedge clk) disable iff (!arstn)
    o_u_rd |=> !o_u_rd) else $error("uart read strobe longer than one cycle");

  a_clear_hold: assert property (@(posedge clk) disable iff (!arstn)
    (clr_cycles < 11'd1024) |-> o_p_hold) else $error("hold low during ram clear");

endmodule

bind spif spif_chk chk (.*);

// File: verification/spif_tb.sv
/* random boot, uart and memory test of spif against models kept here.
   run through run.sh, stops at the first mismatch */
`include "spif_params.svh"

module spif_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import spif_pkg::*;

  localparam int W = `SPIF_WIDTH;

  logic clk = 1'b0, arstn;
  logic i_io_rd, i_io_wr, i_mem_rd, i_mem_wr;
  logic [`SPIF_ADDR_W-1:0] i_mem_addr, i_code_addr;
  logic [W-1:0] i_din, o_mem_dout, o_io_dout;
  logic [`SPIF_INSN_W-1:0] o_insn;
  logic o_p_hold, o_p_reset, i_u_ready, o_u_wr, i_u_full, o_u_rd, i_f_ready, o_f_wr;
  logic [7:0] o_u_dout, i_u_din, o_f_dout, i_f_din;
  logic [3:0] o_f_rate;

  logic [31:0] lfsr = 32'h3acc1550;
  logic [7:0]  script [$];              // flash script bytes
  logic [7:0]  raw_q [$];               // uart bytes as sent
  logic [7:0]  rx_exp [$];              // bytes the cpu should read
  logic [7:0]  tx_q [$];
  logic [15:0] code_m [0:1023];         // ram models
  logic [W-1:0] data_m [0:1023];
  logic [3:0]  exp_rate = `SPIF_RATE_RESET;
  int          n_xfer = 0, wd_cycles = 0;
  logic        rx_on = 1'b0, tx_on = 1'b0;

  spif dut (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // ============================================================
  // compare tasks
  // ============================================================
  task automatic check_word(input string name, input logic [W-1:0] got, exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_insn(input string name, input logic [15:0] got, exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  // fast read header, by transfer number
  function automatic logic [7:0] header_byte(input int n);
    case (n)
      0:       return `SPIF_FAST_READ;
      1:       return `SPIF_BASEBLOCK;
      default: return 8'h00;            // two address zeros and the dummy
    endcase
  endfunction

  // script of length, address and run records plus rate commands
  task automatic build_script();
    logic [31:0] sel, v, addr, len, bb;
    logic [W-1:0] acc;
    for (int s = 0; s < 10; s++) begin
      rand_bits(2, sel);
      if (sel == 0) begin
        rand_bits(4, v);
        script.push_back(8'h80 | v[7:0]);
        exp_rate = v[3:0];
      end else begin
        rand_bits(10, addr);
        rand_bits(3, len);
        rand_bits(2, bb);
        if (bb == 3) bb = 2;
        if (sel == 1 && bb == 2) bb = 1;  // code words fit two bytes
        script.push_back(8'hc1);
        script.push_back(8'h00);
        script.push_back(len[7:0]);
        script.push_back(8'hc0);
        script.push_back({6'd0, addr[9:8]});
        script.push_back(addr[7:0]);
        script.push_back({3'b000, sel[1:0] - 2'd1, 1'b0, bb[1:0]});
        for (int w = 0; w <= int'(len); w++) begin
          acc = '0;
          for (int b = 0; b <= int'(bb); b++) begin
            rand_bits(8, v);
            script.push_back(v[7:0]);
            acc = {acc[W-9:0], v[7:0]};
          end
          if (sel == 1) code_m[(addr + w) & 1023] = acc[15:0];
          if (sel == 2) data_m[(addr + w) & 1023] = acc;
        end
      end
    end
    script.push_back(8'he0);              // end, processor out of reset
  endtask

  task automatic build_rx();
    logic [31:0] t, b;
    for (int i = 0; i < 24; i++) begin
      rand_bits(2, t);
      rand_bits(8, b);
      if (t < 2) begin
        if (b[7:2] == 6'h04) b[6] = 1'b1;  // keep clear of the escape group
        raw_q.push_back(b[7:0]);
        rx_exp.push_back(b[7:0]);
      end else if (t == 2) begin
        raw_q.push_back(`SPIF_ESC_BYTE);
        raw_q.push_back(b[7:0]);
        rx_exp.push_back(8'h10 | {6'd0, b[1:0]});
      end else begin
        raw_q.push_back(8'h11 + {6'd0, (b[1:0] == 2'd3) ? 2'd0 : b[1:0]});
      end
    end
  endtask

  // flash byte port, random ready delay
  initial forever begin
    logic [31:0] d;
    @(posedge clk);
    if (arstn && o_f_wr) begin
      if (n_xfer < 5) check_byte("o_f_dout", o_f_dout, header_byte(n_xfer));
      i_f_ready <= 1'b0;
      rand_bits(2, d);
      repeat (d + 1) @(posedge clk);
      i_f_din   <= (n_xfer >= 5) ? script[n_xfer - 5] : 8'hff;  // header returns
      n_xfer++;
      i_f_ready <= 1'b1;
    end
  end

  // uart receive source
  always @(posedge clk) begin
    if (i_u_full && o_u_rd) begin
      void'(raw_q.pop_front());
      i_u_full <= 1'b0;
    end else if (rx_on && !i_u_full && raw_q.size() > 0) begin
      i_u_din  <= raw_q[0];
      i_u_full <= 1'b1;
    end
  end

  // uart transmit sink and ready toggling
  always @(posedge clk) begin
    logic [31:0] v;
    if (o_u_wr) begin
      if (tx_q.size() == 0) begin
        $display("uart write with no byte pending at %0t", $time);
        stop_run();
      end else begin
        check_byte("o_u_dout", o_u_dout, tx_q.pop_front());
      end
    end
    if (tx_on) begin
      rand_bits(1, v);
      i_u_ready <= v[0];
    end
  end

  task automatic read_all();
    for (int a = 0; a < 1024; a++) begin
      @(posedge clk);
      i_code_addr <= 15'(a);
      i_mem_addr  <= 15'(a);
      i_mem_rd    <= 1'b1;
      @(posedge clk);
      @(posedge clk);
      check_insn("o_insn", o_insn, code_m[a]);
      check_word("o_mem_dout", o_mem_dout, data_m[a]);
    end
    i_mem_rd <= 1'b0;
  endtask

  task automatic write_io(input io_reg_e r, input logic [W-1:0] v);
    @(posedge clk);
    i_mem_addr <= 15'(r);
    i_din      <= v;
    i_io_wr    <= 1'b1;
    do @(posedge clk); while (o_p_hold);  // request held through a stall
    i_io_wr <= 1'b0;
  endtask

  task automatic write_mem(input int a, input logic [W-1:0] v);
    @(posedge clk);
    i_mem_addr <= 15'(a);
    i_din      <= v;
    i_mem_wr   <= 1'b1;
    @(posedge clk);
    i_mem_wr <= 1'b0;
  endtask

  // ============================================================
  // main sequence
  // ============================================================
  initial begin
    logic [31:0] v, base;
    arstn = 1'b0;
    {i_io_rd, i_io_wr, i_mem_rd, i_mem_wr} = 4'b0;
    i_mem_addr = '0;
    i_code_addr = '0;
    i_din = '0;
    i_u_ready = 1'b1;
    i_u_full = 1'b0;
    i_u_din = 8'h00;
    i_f_ready = 1'b1;
    i_f_din = 8'h00;
    for (int a = 0; a < 1024; a++) begin
      code_m[a] = '0;
      data_m[a] = '0;
    end
    build_script();
    build_rx();
    wd_cycles = 1024 + script.size() * 8 * 6 + 40000;
    repeat (8) @(posedge clk);
    arstn <= 1'b1;
    @(posedge clk);
    check_bit("o_p_reset", o_p_reset, 1'b1);  // held until the end command

    // boot, then rams against the script model
    i_mem_addr <= 15'(io_booting);
    do @(posedge clk); while (o_io_dout[0] !== 1'b0);
    @(posedge clk);
    check_bit("o_p_hold", o_p_hold, 1'b0);
    check_bit("o_p_reset", o_p_reset, 1'b0);
    check_byte("o_f_rate", {4'h0, o_f_rate}, {4'h0, exp_rate});
    read_all();

    // uart receive with escapes
    rx_on = 1'b1;
    while (rx_exp.size() > 0) begin
      @(posedge clk);
      i_mem_addr <= 15'(io_rxfull);
      do @(posedge clk); while (o_io_dout[0] !== 1'b1);
      i_mem_addr <= 15'(io_uart);
      i_io_rd    <= 1'b1;
      @(posedge clk);
      check_byte("io_uart", o_io_dout[7:0], rx_exp.pop_front());
      i_io_rd <= 1'b0;
    end
    while (raw_q.size() > 0) @(posedge clk);
    i_mem_addr <= 15'(io_rxfull);
    repeat (3) @(posedge clk);
    check_bit("io_rxfull", o_io_dout[0], 1'b0);

    // uart transmit under random ready
    tx_on = 1'b1;
    repeat (12) begin
      rand_bits(8, v);
      tx_q.push_back(v[7:0]);
      write_io(io_uart, 18'(v[7:0]));
    end
    while (tx_q.size() > 0) @(posedge clk);
    tx_on = 1'b0;
    i_u_ready <= 1'b1;

    // processor code and data writes
    rand_bits(10, base);
    write_io(io_code_addr, 18'(base[9:0]));
    for (int i = 0; i < 8; i++) begin
      rand_bits(16, v);
      write_io(io_code_data, 18'(v[15:0]));
      code_m[(base + i) & 1023] = v[15:0];
    end
    for (int i = 0; i < 16; i++) begin
      rand_bits(10, base);
      rand_bits(18, v);
      write_mem(int'(base[9:0]), v[W-1:0]);
      data_m[base[9:0]] = v[W-1:0];
    end
    read_all();

    $display("ALL CHECKS PASSED");
    $finish;
  end

  // watchdog, limit set once the script length is known
  initial begin
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", wd_cycles);
    stop_run();
  end

endmodule

// File: spif.f
+incdir+include
design/spif_pkg.sv
design/spif_if.sv
design/spram.sv
design/boot_interp.sv
design/uart_port.sv
design/mem_port.sv
design/spif.sv
verification/spif_chk.sv
verification/spif_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the spif testbench with Verilator, run it and scan the log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f spif.f --top-module spif_tb \
  -o spif_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/spif_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

echo "simulation clean"
exit 0
